// ==== list.f ====
rtl/bp_pkg.sv
rtl/branch_history_table.sv
rtl/pattern_history_table.sv
rtl/branch_target_buffer.sv
rtl/b_predictor.sv
verification/tb_b_predictor.sv

// ==== rtl/b_predictor.sv ====
`default_nettype none
`timescale 1ns/1ns

module b_predictor #(
    parameter int BHT_NUM   = 1024,
    parameter int BHT_WIDTH = 6,
    parameter int BTB_NUM   = 64
) (
    input  logic               clk,
    input  logic               rst,

    // fetch lookup
    input  bp_pkg::pc_t        pc,
    output bp_pkg::bp_pred_t   pred,

    // resolved branch from execute
    input  logic               update,
    input  bp_pkg::bp_update_t upd_info
);

    localparam int BHT_IDX_W = $clog2(BHT_NUM);

    typedef logic [BHT_IDX_W-1:0] bht_index_t;
    typedef logic [BHT_WIDTH-1:0] history_t; // also the pht index width

    bht_index_t       bht_rd_index;
    bht_index_t       bht_wr_index;
    history_t         bht_rd_history;
    history_t         bht_wr_history;

    history_t         pht_rd_index;
    history_t         pht_wr_index;
    bp_pkg::counter_t pht_rd_state;

    logic             btb_hit;
    bp_pkg::pc_t      btb_target;
    logic             btb_wr_en;

    // ****************************************
    // index generation
    // ****************************************

    assign bht_rd_index = pc[bp_pkg::PC_LSB +: BHT_IDX_W];
    assign bht_wr_index = upd_info.pc[bp_pkg::PC_LSB +: BHT_IDX_W];

    // history folded into the top bits of the bht index
    assign pht_rd_index = bht_rd_history ^ bht_rd_index[BHT_IDX_W-1 -: BHT_WIDTH];
    assign pht_wr_index = bht_wr_history ^ bht_wr_index[BHT_IDX_W-1 -: BHT_WIDTH]; // old history

    // only taken branches allocate a target
    assign btb_wr_en = update & upd_info.taken;

    // ****************************************
    // tables
    // ****************************************

    branch_history_table #(
        .BHT_NUM    (BHT_NUM),
        .BHT_WIDTH  (BHT_WIDTH)
    ) u_bht (
        .clk        (clk),
        .rst        (rst),
        .rd_index   (bht_rd_index),
        .rd_history (bht_rd_history),
        .wr_en      (update),
        .wr_index   (bht_wr_index),
        .wr_taken   (upd_info.taken),
        .wr_history (bht_wr_history)
    );

    pattern_history_table #(
        .BHT_WIDTH  (BHT_WIDTH)
    ) u_pht (
        .clk        (clk),
        .rst        (rst),
        .rd_index   (pht_rd_index),
        .rd_state   (pht_rd_state),
        .wr_en      (update),
        .wr_index   (pht_wr_index),
        .wr_taken   (upd_info.taken)
    );

    branch_target_buffer #(
        .BTB_NUM    (BTB_NUM)
    ) u_btb (
        .clk        (clk),
        .rst        (rst),
        .pc         (pc),
        .hit        (btb_hit),
        .target     (btb_target),
        .wr_en      (btb_wr_en),
        .wr_pc      (upd_info.pc),
        .wr_target  (upd_info.target)
    );

    // ****************************************
    // prediction
    // ****************************************

    always_comb begin
        pred.taken  = pht_rd_state[1] & btb_hit; // no target, no taken
        pred.target = btb_target;
    end

endmodule

`default_nettype wire

// ==== rtl/bp_pkg.sv ====
`default_nettype none

package bp_pkg;

    // ****************************************
    // basic types
    // ****************************************

    localparam int PC_WIDTH = 32;

    // fetch is 8-byte aligned, bits below this never index anything
    localparam int PC_LSB = 3;

    typedef logic [PC_WIDTH-1:0] pc_t;

    // 2-bit saturating counter, msb is the taken prediction
    typedef enum logic [1:0] {
        strong_not_taken = 2'd0,
        weak_not_taken   = 2'd1,
        weak_taken       = 2'd2,
        strong_taken     = 2'd3
    } counter_t;

    // ****************************************
    // prediction and update records
    // ****************************************

    typedef struct packed {
        logic taken;
        pc_t  target; // btb word, valid even on a miss
    } bp_pred_t;

    typedef struct packed {
        pc_t  pc;     // branch address
        logic taken;  // resolved direction
        pc_t  target; // resolved target
    } bp_update_t;

endpackage

`default_nettype wire

// ==== rtl/branch_history_table.sv ====
`default_nettype none
`timescale 1ns/1ns

module branch_history_table #(
    parameter int BHT_NUM   = 1024,
    parameter int BHT_WIDTH = 6
) (
    input  logic                       clk,
    input  logic                       rst,

    // lookup side
    input  logic [$clog2(BHT_NUM)-1:0] rd_index,
    output logic [BHT_WIDTH-1:0]       rd_history,

    // update side
    input  logic                       wr_en,
    input  logic [$clog2(BHT_NUM)-1:0] wr_index,
    input  logic                       wr_taken,
    output logic [BHT_WIDTH-1:0]       wr_history
);

    typedef logic [BHT_WIDTH-1:0] history_t;

    history_t hist [BHT_NUM]; // one outcome shift register per entry
    history_t hist_shifted;

    // ****************************************
    // read ports
    // ****************************************

    assign rd_history = hist[rd_index];
    assign wr_history = hist[wr_index]; // pre-update value

    // newest outcome enters at bit 0
    assign hist_shifted = {wr_history[BHT_WIDTH-2:0], wr_taken};

    // ****************************************
    // update
    // ****************************************

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < BHT_NUM; i++) begin
                hist[i] <= '0;
            end
        end else if (wr_en) begin
            hist[wr_index] <= hist_shifted;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/branch_target_buffer.sv ====
`default_nettype none
`timescale 1ns/1ns

module branch_target_buffer #(
    parameter int BTB_NUM = 64
) (
    input  logic        clk,
    input  logic        rst,

    // lookup side
    input  bp_pkg::pc_t pc,
    output logic        hit,
    output bp_pkg::pc_t target,

    // update side
    input  logic        wr_en,
    input  bp_pkg::pc_t wr_pc,
    input  bp_pkg::pc_t wr_target
);

    localparam int IDX_W   = $clog2(BTB_NUM);
    localparam int TAG_LSB = bp_pkg::PC_LSB + IDX_W;
    localparam int TAG_W   = bp_pkg::PC_WIDTH - TAG_LSB; // all pc bits above the index

    typedef logic [IDX_W-1:0] btb_index_t;
    typedef logic [TAG_W-1:0] btb_tag_t;

    // ****************************************
    // storage
    // ****************************************

    logic        valid      [BTB_NUM];
    btb_tag_t    tag_mem    [BTB_NUM];
    bp_pkg::pc_t target_mem [BTB_NUM];

    btb_index_t  rd_idx;
    btb_tag_t    rd_tag;
    btb_index_t  wr_idx;
    btb_tag_t    wr_tag;

    // ****************************************
    // field extraction
    // ****************************************

    assign rd_idx = pc[bp_pkg::PC_LSB +: IDX_W];
    assign rd_tag = pc[bp_pkg::PC_WIDTH-1:TAG_LSB];

    assign wr_idx = wr_pc[bp_pkg::PC_LSB +: IDX_W];
    assign wr_tag = wr_pc[bp_pkg::PC_WIDTH-1:TAG_LSB];

    // ****************************************
    // lookup
    // ****************************************

    // target is driven from the indexed entry even on a miss
    assign hit    = valid[rd_idx] && (tag_mem[rd_idx] == rd_tag);
    assign target = target_mem[rd_idx];

    // ****************************************
    // update
    // ****************************************

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < BTB_NUM; i++) begin
                valid[i] <= 1'b0;
            end
        end else if (wr_en) begin
            valid[wr_idx] <= 1'b1;
        end
    end

    // direct-mapped, a write replaces whatever was there
    always_ff @(posedge clk) begin
        if (wr_en) begin
            tag_mem[wr_idx]    <= wr_tag;
            target_mem[wr_idx] <= wr_target;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/pattern_history_table.sv ====
`default_nettype none
`timescale 1ns/1ns

module pattern_history_table #(
    parameter int BHT_WIDTH = 6
) (
    input  logic                 clk,
    input  logic                 rst,

    // lookup side
    input  logic [BHT_WIDTH-1:0] rd_index,
    output bp_pkg::counter_t     rd_state,

    // update side
    input  logic                 wr_en,
    input  logic [BHT_WIDTH-1:0] wr_index,
    input  logic                 wr_taken
);

    localparam int PHT_NUM = 2 ** BHT_WIDTH; // one counter per history pattern

    bp_pkg::counter_t cnt [PHT_NUM];
    bp_pkg::counter_t cnt_next;

    // ****************************************
    // counter next-state function
    // ****************************************

    function automatic bp_pkg::counter_t step(input bp_pkg::counter_t cur,
                                              input logic taken);
        bp_pkg::counter_t nxt;
        nxt = cur;
        case (cur)
            bp_pkg::strong_not_taken:
                nxt = taken ? bp_pkg::weak_not_taken : bp_pkg::strong_not_taken;
            bp_pkg::weak_not_taken:
                nxt = taken ? bp_pkg::weak_taken : bp_pkg::strong_not_taken;
            bp_pkg::weak_taken:
                nxt = taken ? bp_pkg::strong_taken : bp_pkg::weak_not_taken;
            bp_pkg::strong_taken:
                nxt = taken ? bp_pkg::strong_taken : bp_pkg::weak_taken;
            default:
                nxt = bp_pkg::weak_not_taken;
        endcase
        return nxt;
    endfunction

    assign rd_state = cnt[rd_index];
    assign cnt_next = step(cnt[wr_index], wr_taken); // saturates at both ends

    // ****************************************
    // update
    // ****************************************

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < PHT_NUM; i++) begin
                cnt[i] <= bp_pkg::weak_not_taken;
            end
        end else if (wr_en) begin
            cnt[wr_index] <= cnt_next;
        end
    end

endmodule

`default_nettype wire

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the branch predictor testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    -f list.f \
    --top-module tb_b_predictor \
    -o sim_b_predictor \
    && ./obj_dir/sim_b_predictor | tee /dev/stderr | grep -x "Done: no errors" > /dev/null \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

// ==== verification/tb_b_predictor.sv ====
`default_nettype none
`timescale 1ns/1ns

module tb_b_predictor;

    // model widths for the default DUT parameters
    localparam int BHT_NUM   = 1024;
    localparam int BHT_IDX_W = 10;
    localparam int HIST_W    = 6;
    localparam int PHT_NUM   = 64;
    localparam int BTB_NUM   = 64;
    localparam int BTB_IDX_W = 6;
    localparam int TAG_LSB   = bp_pkg::PC_LSB + BTB_IDX_W;

    localparam int RESET_CYCLES   = 10;
    localparam int SWEEP_CYCLES   = 32;
    localparam int TRAIN_CYCLES   = 9;
    localparam int NT_CYCLES      = 14;
    localparam int ALIAS_CYCLES   = 12;
    localparam int COLLIDE_CYCLES = 3;
    localparam int RANDOM_CYCLES  = 300;
    localparam int TIMEOUT_CYCLES = RESET_CYCLES + SWEEP_CYCLES + TRAIN_CYCLES + NT_CYCLES
                                  + ALIAS_CYCLES + COLLIDE_CYCLES + RANDOM_CYCLES + 100;

    localparam logic [31:0] LFSR_SEED = 32'h3ee4_7c77;

    localparam bp_pkg::pc_t PC_A   = 32'h0000_4a40;
    localparam bp_pkg::pc_t TGT_A  = 32'h0000_8000;
    localparam bp_pkg::pc_t PC_B   = 32'h0000_4840; // same btb index as PC_A, other tag
    localparam bp_pkg::pc_t TGT_B  = 32'h0000_9a08;
    localparam bp_pkg::pc_t PC_C   = 32'h0010_4a40; // shares bht entry and btb index with PC_A
    localparam bp_pkg::pc_t TGT_C  = 32'h0002_1000;
    localparam bp_pkg::pc_t PC_E   = 32'h0001_0a18;
    localparam bp_pkg::pc_t TGT_E1 = 32'h0000_3000;
    localparam bp_pkg::pc_t TGT_E2 = 32'h0000_5008;

    logic               clk;
    logic               rst;
    bp_pkg::pc_t        pc;
    bp_pkg::bp_pred_t   pred;
    logic               update;
    bp_pkg::bp_update_t upd_info;

    // reference tables
    logic [HIST_W-1:0]  m_hist   [BHT_NUM];
    logic [1:0]         m_cnt    [PHT_NUM];
    logic               m_valid  [BTB_NUM];
    bp_pkg::pc_t        m_pc     [BTB_NUM]; // tag kept as the whole branch pc
    bp_pkg::pc_t        m_target [BTB_NUM];

    logic [31:0]        lfsr;
    int                 errors;
    int                 checks;
    int                 cycle_cnt = 0;

    b_predictor u_b_predictor (
        .clk      (clk),
        .rst      (rst),
        .pc       (pc),
        .pred     (pred),
        .update   (update),
        .upd_info (upd_info)
    );

    initial clk = 1'b0;
    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("timeout after %0d cycles, the tests did not finish", cycle_cnt);
            $display("Done: errors found");
            $finish;
        end
    end

    // ****************************************
    // random bits and model
    // ****************************************

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]}; // taps 32 22 2 1
    endfunction

    task automatic rand_bits(input int n, output logic [31:0] val);
        val = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            val  = {val[30:0], lfsr[0]};
        end
    endtask

    function automatic logic [BHT_IDX_W-1:0] bht_idx(input bp_pkg::pc_t a);
        return a[bp_pkg::PC_LSB +: BHT_IDX_W];
    endfunction

    function automatic logic [HIST_W-1:0] pht_idx(input bp_pkg::pc_t a);
        return m_hist[bht_idx(a)] ^ a[bp_pkg::PC_LSB + BHT_IDX_W - 1 -: HIST_W];
    endfunction

    function automatic logic [BTB_IDX_W-1:0] btb_idx(input bp_pkg::pc_t a);
        return a[bp_pkg::PC_LSB +: BTB_IDX_W];
    endfunction

    function automatic logic model_hit(input bp_pkg::pc_t a);
        return m_valid[btb_idx(a)] && (m_pc[btb_idx(a)][31:TAG_LSB] == a[31:TAG_LSB]);
    endfunction

    function automatic bp_pkg::bp_update_t mk_upd(input bp_pkg::pc_t a, input logic t,
                                                  input bp_pkg::pc_t tgt);
        bp_pkg::bp_update_t u;
        u.pc     = a;
        u.taken  = t;
        u.target = tgt;
        return u;
    endfunction

    task automatic model_reset();
        for (int i = 0; i < BHT_NUM; i++) begin
            m_hist[i] = '0;
        end
        for (int i = 0; i < PHT_NUM; i++) begin
            m_cnt[i] = 2'd1; // weak not taken
        end
        for (int i = 0; i < BTB_NUM; i++) begin
            m_valid[i] = 1'b0;
        end
    endtask

    task automatic model_update(input bp_pkg::bp_update_t u);
        logic [BHT_IDX_W-1:0] bi;
        logic [HIST_W-1:0]    pi;
        logic [BTB_IDX_W-1:0] ti;
        bi = bht_idx(u.pc);
        pi = pht_idx(u.pc); // old history
        ti = btb_idx(u.pc);
        if (u.taken && m_cnt[pi] != 2'd3) begin
            m_cnt[pi] = m_cnt[pi] + 2'd1;
        end else if (!u.taken && m_cnt[pi] != 2'd0) begin
            m_cnt[pi] = m_cnt[pi] - 2'd1;
        end
        m_hist[bi] = {m_hist[bi][HIST_W-2:0], u.taken};
        if (u.taken) begin
            m_valid[ti]  = 1'b1;
            m_pc[ti]     = u.pc;
            m_target[ti] = u.target;
        end
    endtask

    // ****************************************
    // checks and cycle helpers
    // ****************************************

    task automatic check_pred(input string what);
        logic        exp_taken;
        bp_pkg::pc_t exp_target;
        logic [1:0]  c;
        c          = m_cnt[pht_idx(pc)];
        exp_taken  = c[1] & model_hit(pc);
        exp_target = m_target[btb_idx(pc)];
        checks++;
        assert (pred.taken === exp_taken) else begin
            $display("** Error at %0t ns: %s pc %h taken expected %b got %b",
                     $time, what, pc, exp_taken, pred.taken);
            errors++;
        end
        if (m_valid[btb_idx(pc)]) begin // no known target before the first write
            assert (pred.target === exp_target) else begin
                $display("** Error at %0t ns: %s pc %h target expected %h got %h",
                         $time, what, pc, exp_target, pred.target);
                errors++;
            end
        end
    endtask

    task automatic expect_value(input string what, input logic [31:0] exp,
                                input logic [31:0] act);
        checks++;
        assert (act === exp) else begin
            $display("** Error at %0t ns: %s pc %h expected %h got %h",
                     $time, what, pc, exp, act);
            errors++;
        end
    endtask

    task automatic start_cycle(input bp_pkg::pc_t lpc, input logic upd,
                               input bp_pkg::bp_update_t info, input string what);
        pc       = lpc;
        update   = upd;
        upd_info = info;
        #4; // sample mid cycle
        check_pred(what);
    endtask

    task automatic end_cycle();
        @(posedge clk);
        if (update) begin
            model_update(upd_info);
        end
        #1;
    endtask

    task automatic do_cycle(input bp_pkg::pc_t lpc, input logic upd,
                            input bp_pkg::bp_update_t info, input string what);
        start_cycle(lpc, upd, info, what);
        end_cycle();
    endtask

    // ****************************************
    // directed tests
    // ****************************************

    task automatic sweep_after_reset();
        logic [31:0] r;
        for (int i = 0; i < SWEEP_CYCLES; i++) begin
            rand_bits(29, r);
            start_cycle({r[28:0], 3'b000}, 1'b0, '0, "reset sweep");
            expect_value("reset sweep taken", 32'd0, 32'(pred.taken));
            end_cycle();
        end
    endtask

    task automatic train_branch_taken();
        repeat (8) do_cycle(PC_A, 1'b1, mk_upd(PC_A, 1'b1, TGT_A), "train taken");
        start_cycle(PC_A, 1'b0, '0, "trained lookup");
        expect_value("trained taken", 32'd1, 32'(pred.taken));
        expect_value("trained target", TGT_A, pred.target);
        end_cycle();
    endtask

    task automatic untrain_branch();
        for (int i = 0; i < 4; i++) begin
            start_cycle(PC_B, 1'b1, mk_upd(PC_B, 1'b0, TGT_B), "not-taken update");
            expect_value("not-taken branch taken", 32'd0, 32'(pred.taken));
            expect_value("not-taken branch target", TGT_A, pred.target);
            end_cycle();
        end
        // a btb write by PC_B would have evicted PC_A
        start_cycle(PC_A, 1'b0, '0, "neighbour after not-taken");
        expect_value("neighbour taken", 32'd1, 32'(pred.taken));
        expect_value("neighbour target", TGT_A, pred.target);
        end_cycle();
        repeat (8) do_cycle(PC_A, 1'b1, mk_upd(PC_A, 1'b0, TGT_A), "untrain");
        start_cycle(PC_A, 1'b0, '0, "untrained lookup");
        expect_value("untrained taken", 32'd0, 32'(pred.taken));
        end_cycle();
    endtask

    task automatic alias_btb_entry();
        repeat (8) do_cycle(PC_A, 1'b1, mk_upd(PC_A, 1'b1, TGT_A), "retrain");
        start_cycle(PC_C, 1'b0, '0, "alias lookup");
        assert (m_cnt[pht_idx(PC_C)][1] === 1'b1) else begin
            $display("alias test setup is wrong, the counter for pc %h does not read taken",
                     PC_C);
            errors++;
        end
        expect_value("alias taken", 32'd0, 32'(pred.taken));
        expect_value("alias target", TGT_A, pred.target);
        end_cycle();
        do_cycle(PC_A, 1'b1, mk_upd(PC_C, 1'b1, TGT_C), "alias replace");
        start_cycle(PC_A, 1'b0, '0, "evicted lookup");
        expect_value("evicted taken", 32'd0, 32'(pred.taken));
        expect_value("evicted target", TGT_C, pred.target);
        end_cycle();
        start_cycle(PC_C, 1'b0, '0, "new owner lookup");
        expect_value("new owner taken", 32'd1, 32'(pred.taken));
        end_cycle();
    endtask

    task automatic collide_lookup_update();
        do_cycle(PC_E, 1'b1, mk_upd(PC_E, 1'b1, TGT_E1), "first update");
        start_cycle(PC_E, 1'b1, mk_upd(PC_E, 1'b1, TGT_E2), "lookup during update");
        expect_value("old target", TGT_E1, pred.target);
        end_cycle();
        start_cycle(PC_E, 1'b0, '0, "lookup after update");
        expect_value("new target", TGT_E2, pred.target);
        end_cycle();
    endtask

    task automatic run_random_stream();
        bp_pkg::pc_t        pool [8];
        logic [31:0]        r;
        bp_pkg::pc_t        lpc;
        logic               upd;
        bp_pkg::bp_update_t u;
        for (int i = 0; i < 8; i++) begin
            rand_bits(29, r);
            pool[i] = {r[28:0], 3'b000} & 32'h0010_1e38; // few indices, tags collide
        end
        for (int i = 0; i < RANDOM_CYCLES; i++) begin
            rand_bits(3, r);
            lpc = pool[r[2:0]];
            rand_bits(2, r);
            upd = (r[1:0] != 2'b00); // update on three cycles of four
            rand_bits(3, r);
            u.pc = pool[r[2:0]];
            rand_bits(1, r);
            u.taken = r[0];
            rand_bits(29, r);
            u.target = {r[28:0], 3'b000};
            do_cycle(lpc, upd, u, "random");
        end
    endtask

    // ****************************************
    // main sequence
    // ****************************************

    initial begin
        errors   = 0;
        checks   = 0;
        lfsr     = LFSR_SEED;
        rst      = 1'b1;
        pc       = '0;
        update   = 1'b0;
        upd_info = '0;
        model_reset();
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst = 1'b0;

        sweep_after_reset();
        train_branch_taken();
        untrain_branch();
        alias_btb_entry();
        collide_lookup_update();
        run_random_stream();

        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire
